// File: include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath width, registers and pc
`define XLEN 32

// architectural register count, x0 included
`define NUM_REGS 32

// bits needed to name one register
`define REG_IDX_W 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// shift amount taken from rs2 or the immediate
`define SHAMT_W 5

`endif

// File: src/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  // major opcodes handled by the core, everything else is illegal
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // values follow funct3 so the decoder can cast directly
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_op_e;

  typedef enum logic [1:0] {
    f_req,
    f_exec,
    f_release,
    f_halted
  } fetch_state_e;

  typedef struct packed {
    alu_op_e               alu_op;
    branch_op_e            branch_op;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`XLEN-1:0]      imm;
    logic                  uses_imm;   // operand b from imm
    logic                  is_lui;
    logic                  is_auipc;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  writes_rd;
    logic                  halt_req;   // ecall or illegal
  } decoded_insn_t;

  typedef struct packed {
    logic                  valid;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      next_pc;
    logic                  rd_we;      // never set for x0
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      rd_data;
    logic                  halt;
  } retire_t;

endpackage

// File: src/fetch_unit.sv
`include "rv_defs.svh"

module fetch_unit (
  input  logic             clk,
  input  logic             rst,
  output logic             imem_req,
  output logic [`XLEN-1:0] imem_addr,
  input  logic             imem_ack,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] insn,
  output logic [`XLEN-1:0] pc,
  output logic             exec_en,
  input  rv_pkg::retire_t  retire,
  output logic             halt
);

  rv_pkg::fetch_state_e state;

  // req comes straight from the state, so it drops as soon as ack is taken
  assign imem_req  = (state == rv_pkg::f_req);
  assign imem_addr = pc;
  assign exec_en   = (state == rv_pkg::f_exec);

  always_ff @(posedge clk) begin
    if (rst) begin
      // start in release so req stays low until ack is seen low
      state <= rv_pkg::f_release;
      pc    <= `RESET_PC;
      halt  <= 1'b0;
    end else begin
      case (state)
        rv_pkg::f_req: begin
          if (imem_ack) begin
            state <= rv_pkg::f_exec;
          end
        end
        rv_pkg::f_exec: begin
          if (retire.valid && retire.halt) begin
            state <= rv_pkg::f_halted;
            halt  <= 1'b1;  // sticky until reset
          end else begin
            state <= rv_pkg::f_release;
            pc    <= retire.next_pc;
          end
        end
        rv_pkg::f_release: begin
          if (!imem_ack) begin  // phase 4 done
            state <= rv_pkg::f_req;
          end
        end
        default: begin
          state <= rv_pkg::f_halted;
        end
      endcase
    end
  end

  // instruction word captured with the ack, held through f_exec
  always_ff @(posedge clk) begin
    if (state == rv_pkg::f_req && imem_ack) begin
      insn <= imem_data;
    end
  end

endmodule

// File: src/insn_decoder.sv
`include "rv_defs.svh"

module insn_decoder (
  input  logic [`XLEN-1:0]      insn,
  output rv_pkg::decoded_insn_t dec
);

  logic [6:0]            funct7;
  logic [`REG_IDX_W-1:0] rs2;
  logic [`REG_IDX_W-1:0] rs1;
  logic [2:0]            funct3;
  logic [`REG_IDX_W-1:0] rd;
  logic [6:0]            opcode;
  logic [`XLEN-1:0]      imm_i;
  logic [`XLEN-1:0]      imm_b;
  logic [`XLEN-1:0]      imm_j;
  logic [`XLEN-1:0]      imm_u;
  logic [`XLEN-1:0]      imm_shamt;
  logic                  funct7_zero;
  logic                  funct7_alt;
  logic                  illegal;
  rv_pkg::alu_op_e       alu_base;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = insn;

  assign imm_i     = {{(`XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_b     = {{(`XLEN-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j     = {{(`XLEN-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u     = {insn[31:12], 12'b0};
  assign imm_shamt = {{(`XLEN-`SHAMT_W){1'b0}}, insn[20 +: `SHAMT_W]};

  assign funct7_zero = (funct7 == 7'b0000000);
  assign funct7_alt  = (funct7 == 7'b0100000);  // sub, sra, srai

  // common funct3 to alu mapping for reg and imm forms
  always_comb begin
    case (funct3)
      3'b000:  alu_base = rv_pkg::alu_add;
      3'b001:  alu_base = rv_pkg::alu_sll;
      3'b010:  alu_base = rv_pkg::alu_slt;
      3'b011:  alu_base = rv_pkg::alu_sltu;
      3'b100:  alu_base = rv_pkg::alu_xor;
      3'b101:  alu_base = funct7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_base = rv_pkg::alu_or;
      default: alu_base = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    dec           = '0;
    dec.alu_op    = rv_pkg::alu_add;
    dec.branch_op = rv_pkg::br_beq;
    dec.rd        = rd;
    dec.rs1       = rs1;
    dec.rs2       = rs2;
    illegal       = 1'b0;
    case (opcode)
      rv_pkg::op_reg: begin
        dec.writes_rd = 1'b1;
        dec.alu_op    = (funct3 == 3'b000 && funct7_alt) ? rv_pkg::alu_sub : alu_base;
        // only add/sub and srl/sra accept the alternate funct7
        illegal = !(funct7_zero || (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      rv_pkg::op_imm: begin
        dec.writes_rd = 1'b1;
        dec.uses_imm  = 1'b1;
        dec.alu_op    = alu_base;
        dec.imm       = (funct3[1:0] == 2'b01) ? imm_shamt : imm_i;
        if (funct3 == 3'b001) begin
          illegal = !funct7_zero;
        end else if (funct3 == 3'b101) begin
          illegal = !(funct7_zero || funct7_alt);
        end
      end
      rv_pkg::op_lui: begin
        dec.writes_rd = 1'b1;
        dec.is_lui    = 1'b1;
        dec.imm       = imm_u;
      end
      rv_pkg::op_auipc: begin
        dec.writes_rd = 1'b1;
        dec.is_auipc  = 1'b1;
        dec.imm       = imm_u;
      end
      rv_pkg::op_jal: begin
        dec.writes_rd = 1'b1;
        dec.is_jal    = 1'b1;
        dec.imm       = imm_j;
      end
      rv_pkg::op_jalr: begin
        dec.writes_rd = 1'b1;
        dec.is_jalr   = 1'b1;
        dec.imm       = imm_i;
        illegal       = (funct3 != 3'b000);
      end
      rv_pkg::op_branch: begin
        dec.is_branch = 1'b1;
        dec.imm       = imm_b;
        dec.branch_op = rv_pkg::branch_op_e'(funct3);
        illegal       = (funct3[2:1] == 2'b01);  // 010 and 011 unused
      end
      rv_pkg::op_system: dec.halt_req = 1'b1;  // ecall, other system ops unsupported
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      dec.halt_req  = 1'b1;
      dec.writes_rd = 1'b0;
    end
  end

endmodule

// File: src/reg_file.sv
`include "rv_defs.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data,
  input  rv_pkg::retire_t       wr
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 stays zero, rd_we is never set for it
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.rd_we) begin
      regs[wr.rd] <= wr.rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// File: src/execute_unit.sv
`include "rv_defs.svh"

module execute_unit (
  input  logic                  exec_en,
  input  logic [`XLEN-1:0]      pc,
  input  rv_pkg::decoded_insn_t dec,
  input  logic [`XLEN-1:0]      rs1_data,
  input  logic [`XLEN-1:0]      rs2_data,
  output rv_pkg::retire_t       result
);

  logic [`XLEN-1:0]    op_b;
  logic [`SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]    alu_out;
  logic [`XLEN-1:0]    pc_plus4;
  logic [`XLEN-1:0]    pc_rel;
  logic [`XLEN-1:0]    jalr_target;
  logic [`XLEN-1:0]    next_pc;
  logic [`XLEN-1:0]    wb_data;
  logic                taken;

  assign op_b        = dec.uses_imm ? dec.imm : rs2_data;
  assign shamt       = op_b[`SHAMT_W-1:0];
  assign pc_plus4    = pc + `XLEN'(4);
  assign pc_rel      = pc + dec.imm;  // shared by branch, jal and auipc
  assign jalr_target = (rs1_data + dec.imm) & ~`XLEN'(1);

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:  alu_out = rs1_data + op_b;
      rv_pkg::alu_sub:  alu_out = rs1_data - op_b;
      rv_pkg::alu_sll:  alu_out = rs1_data << shamt;
      rv_pkg::alu_slt:  alu_out = `XLEN'($signed(rs1_data) < $signed(op_b));
      rv_pkg::alu_sltu: alu_out = `XLEN'(rs1_data < op_b);
      rv_pkg::alu_xor:  alu_out = rs1_data ^ op_b;
      rv_pkg::alu_srl:  alu_out = rs1_data >> shamt;
      rv_pkg::alu_sra:  alu_out = $signed(rs1_data) >>> shamt;
      rv_pkg::alu_or:   alu_out = rs1_data | op_b;
      default:          alu_out = rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (dec.branch_op)
      rv_pkg::br_beq:  taken = (rs1_data == rs2_data);
      rv_pkg::br_bne:  taken = (rs1_data != rs2_data);
      rv_pkg::br_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::br_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::br_bltu: taken = (rs1_data < rs2_data);
      rv_pkg::br_bgeu: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = jalr_target;
    end else if (dec.is_jal || (dec.is_branch && taken)) begin
      next_pc = pc_rel;
    end else begin
      next_pc = pc_plus4;
    end

    if (dec.is_lui) begin
      wb_data = dec.imm;
    end else if (dec.is_auipc) begin
      wb_data = pc_rel;
    end else if (dec.is_jal || dec.is_jalr) begin
      wb_data = pc_plus4;  // link value
    end else begin
      wb_data = alu_out;
    end
  end

  assign result.valid   = exec_en;
  assign result.pc      = pc;
  assign result.next_pc = next_pc;
  assign result.rd_we   = dec.writes_rd && (dec.rd != '0) && !dec.halt_req;
  assign result.rd      = dec.rd;
  assign result.rd_data = wb_data;
  assign result.halt    = dec.halt_req;

endmodule

// File: src/rv_core.sv
`include "rv_defs.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst,
  output logic             imem_req,
  output logic [`XLEN-1:0] imem_addr,
  input  logic             imem_ack,
  input  logic [`XLEN-1:0] imem_data,
  output rv_pkg::retire_t  retire,
  output logic             halt
);

  logic [`XLEN-1:0]      insn;
  logic [`XLEN-1:0]      pc;
  logic                  exec_en;
  rv_pkg::decoded_insn_t dec;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;

  fetch_unit u_fetch (
    .clk       (clk),
    .rst       (rst),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .imem_data (imem_data),
    .insn      (insn),
    .pc        (pc),
    .exec_en   (exec_en),
    .retire    (retire),
    .halt      (halt)
  );

  insn_decoder u_decode (
    .insn (insn),
    .dec  (dec)
  );

  // the retire record doubles as the write port
  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (retire)
  );

  execute_unit u_exec (
    .exec_en  (exec_en),
    .pc       (pc),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (retire)
  );

endmodule

// File: test/tb_rv_core.sv
`include "rv_defs.svh"

module tb_rv_core;

  localparam int PROG_WORDS   = 256;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_RETIRES  = 2000;
  localparam int POST_HALT    = 20;
  localparam int MAX_CYCLES   = MAX_RETIRES * 10 + RESET_CYCLES + POST_HALT;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic                  clk;
  logic                  rst;
  logic                  imem_req;
  logic [`XLEN-1:0]      imem_addr;
  logic                  imem_ack;
  logic [`XLEN-1:0]      imem_data;
  rv_pkg::retire_t       retire;
  logic                  halt;

  logic [31:0]           prog [PROG_WORDS];
  logic [`XLEN-1:0]      xreg [`NUM_REGS];  // model register file
  logic [`XLEN-1:0]      model_pc;
  logic [`XLEN-1:0]      addr_prev;
  logic                  req_prev;
  logic                  ack_taken;  // dut samples ack high at the coming edge
  logic                  halted;
  logic                  first_retire;
  logic                  done;
  int                    seed;
  int                    cycles;
  int                    retired;
  int                    post_halt;
  int                    delay;
  int                    i;

  rv_core UUT (
    .clk       (clk),
    .rst       (rst),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .imem_data (imem_data),
    .retire    (retire),
    .halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // random kept instruction for word idx with targets inside the program
  function automatic logic [31:0] gen_insn(input int idx);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [31:0] raw;
    int          tgt;
    int          k;
    rd  = 5'(rnd(32));
    rs1 = 5'(rnd(32));
    rs2 = 5'(rnd(32));
    f3  = 3'(rnd(8));
    f7  = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00;
    tgt = rnd(PROG_WORDS);
    if (tgt == idx) begin
      tgt = (idx + 1) % PROG_WORDS;
    end
    boff = 13'((tgt - idx) * 4);
    joff = 21'((tgt - idx) * 4);
    if (rnd(60) == 0) begin
      raw = $random(seed);
      if (rnd(2) == 0) begin
        return {raw[31:7], 7'b0000011};  // load opcode is not kept
      end
      return {7'h01, rs2, rs1, f3, rd, 7'b0110011};  // mul encoding
    end
    case (rnd(8))
      0, 1: return {f7, rs2, rs1, f3, rd, 7'b0110011};
      2, 3: begin
        if (f3[1:0] == 2'b01) begin
          return {f7, rs2, rs1, f3, rd, 7'b0010011};  // rs2 field is shamt
        end
        return {12'(rnd(4096)), rs1, f3, rd, 7'b0010011};
      end
      4: begin
        if (rnd(2) == 0) begin
          return {20'(rnd(1 << 20)), rd, 7'b0110111};
        end
        return {20'(rnd(1 << 20)), rd, 7'b0010111};
      end
      5, 6: begin
        k  = rnd(6);
        f3 = 3'(k < 2 ? k : k + 2);
        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      end
      default: begin
        if (rnd(2) == 0) begin
          return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        end
        return {12'(rnd(PROG_WORDS) * 4), 5'd0, 3'd0, rd, 7'b1100111};  // jalr off x0
      end
    endcase
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr < PROG_WORDS * 4) begin
      return prog[addr[9:2]];
    end
    return ECALL;  // outside the program
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // executes the instruction at model_pc and compares with the retire record
  task automatic check_retire();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] npc;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr;
    logic        stop;
    logic        taken;
    w     = fetch_word(model_pc);
    rd    = w[11:7];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = xreg[w[19:15]];
    b     = xreg[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    npc   = model_pc + 4;
    res   = '0;
    wr    = 1'b0;
    stop  = 1'b0;
    case (w[6:0])
      7'b0110011: begin
        stop = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        res  = alu_ref(f3, w[30], a, b);
        wr   = 1'b1;
      end
      7'b0010011: begin
        stop = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        res  = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
        wr   = 1'b1;
      end
      7'b0110111: begin
        res = {w[31:12], 12'b0};
        wr  = 1'b1;
      end
      7'b0010111: begin
        res = model_pc + {w[31:12], 12'b0};
        wr  = 1'b1;
      end
      7'b1101111: begin
        res = model_pc + 4;  // link
        npc = model_pc + imm_j;
        wr  = 1'b1;
      end
      7'b1100111: begin
        stop = (f3 != 3'd0);
        res  = model_pc + 4;
        npc  = (a + imm_i) & ~32'd1;
        wr   = 1'b1;
      end
      7'b1100011: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          3'd7: taken = (a >= b);
          default: begin
            taken = 1'b0;
            stop  = 1'b1;
          end
        endcase
        if (taken) begin
          npc = model_pc + imm_b;
        end
      end
      default: stop = 1'b1;  // ecall and unsupported opcodes
    endcase
    wr = wr && !stop && (rd != 5'd0);
    check_val("retire.pc", retire.pc, model_pc);
    check_val("retire.halt", 32'(retire.halt), 32'(stop));
    check_val("retire.rd_we", 32'(retire.rd_we), 32'(wr));
    if (wr) begin
      check_val("retire.rd", 32'(retire.rd), 32'(rd));
      check_val("retire.rd_data", retire.rd_data, res);
      xreg[rd] = res;
    end
    if (!stop) begin
      check_val("retire.next_pc", retire.next_pc, npc);
    end
    model_pc = npc;
    halted   = stop;
  endtask

  initial begin
    seed         = 32'h423b_1b96;
    rst          = 1'b1;
    imem_ack     = 1'b0;
    imem_data    = '0;
    cycles       = 0;
    retired      = 0;
    post_halt    = 0;
    done         = 1'b0;
    halted       = 1'b0;
    first_retire = 1'b1;
    req_prev     = 1'b0;
    addr_prev    = '0;
    ack_taken    = 1'b0;
    model_pc     = `RESET_PC;
    for (i = 0; i < `NUM_REGS; i++) begin
      xreg[i] = '0;
    end
    for (i = 0; i < PROG_WORDS - 1; i++) begin
      prog[i] = gen_insn(i);
    end
    prog[PROG_WORDS-1] = ECALL;
    delay = rnd(4);

    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      cycles++;
      check_val("imem_req", 32'(imem_req), 32'd0);
      check_val("retire.valid", 32'(retire.valid), 32'd0);
      check_val("halt", 32'(halt), 32'd0);
    end
    rst = 1'b0;

    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        abort_run($sformatf("timeout: run still going after %0d cycles", cycles));
      end
      // ack still holds the value the dut saw at the last edge
      if (imem_req && !req_prev && imem_ack) begin
        abort_run("imem_req rose while imem_ack was still high");
      end
      if (req_prev && !imem_req && !imem_ack) begin
        abort_run("imem_req dropped before imem_ack was seen");
      end
      if (req_prev && imem_req && imem_addr != addr_prev) begin
        abort_run("imem_addr changed while imem_req was high");
      end
      check_val("retire.valid", 32'(retire.valid), 32'(ack_taken));
      check_val("halt", 32'(halt), 32'(halted));
      if (halted) begin
        check_val("imem_req after halt", 32'(imem_req), 32'd0);
        post_halt++;
        done = (post_halt == POST_HALT);
      end else if (retire.valid) begin
        check_val("imem_req in exec", 32'(imem_req), 32'd0);
        if (first_retire) begin
          check_val("first retire pc", retire.pc, `RESET_PC);
          first_retire = 1'b0;
        end
        check_retire();
        retired++;
        done = (retired == MAX_RETIRES) && !halted;
      end

      // memory side of the four-phase handshake
      if (!imem_ack) begin
        if (imem_req) begin
          if (delay == 0) begin
            check_val("imem_addr", imem_addr, model_pc);
            imem_ack  = 1'b1;
            imem_data = fetch_word(imem_addr);
            delay     = rnd(4);
          end else begin
            delay--;
          end
        end
      end else if (!imem_req) begin
        if (delay == 0) begin
          imem_ack  = 1'b0;
          imem_data = '0;
          delay     = rnd(4);
        end else begin
          delay--;
        end
      end
      ack_taken = imem_req && imem_ack;
      req_prev  = imem_req;
      addr_prev = imem_addr;
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
src/rv_pkg.sv
src/fetch_unit.sv
src/insn_decoder.sv
src/reg_file.sv
src/execute_unit.sv
src/rv_core.sv
test/tb_rv_core.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing
TOP   = tb_rv_core
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
